/* hw/pr_cfg_pkg.sv */
package pr_cfg_pkg;

    localparam int V_AWIDTH = 6;        // 64 vertices
    localparam int V_VWIDTH = 16;
    localparam int ITER_WIDTH = 4;
    localparam int DELTA_DWIDTH = V_VWIDTH + ITER_WIDTH;  // {value, tag}

    localparam int RAM_RD_LAT = 2;
    // read, add and write stages must all clear before the same address is read again
    localparam int HAZARD_WINDOW = RAM_RD_LAT + 2;
    localparam int ISSUE_TO_RESULT_LAT = HAZARD_WINDOW + 1;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AWIDTH = $clog2(FIFO_DEPTH);
    localparam int FIFO_CWIDTH = FIFO_AWIDTH + 1;
    localparam int FIFO_PROG_FULL = 12;

    localparam int INFLIGHT_WIDTH = 4;

    localparam int E2_SHIFT = 4;        // activity threshold is rank >> E2_SHIFT

endpackage

/* hw/pr_types_pkg.sv */
package pr_types_pkg;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_INIT,    // sweep over all vertices
        ST_RUN
    } core_state_e;

endpackage

/* hw/vertex_ram.sv */
module vertex_ram
    import pr_cfg_pkg::*;
#(
    parameter int AWIDTH = V_AWIDTH,
    parameter int DWIDTH = V_VWIDTH
) (
    input  logic              clk,
    input  logic              we,
    input  logic [AWIDTH-1:0] waddr,
    input  logic [DWIDTH-1:0] wdata,
    input  logic [AWIDTH-1:0] raddr,
    output logic [DWIDTH-1:0] rdata
);

    logic [DWIDTH-1:0] mem [2**AWIDTH];
    logic [DWIDTH-1:0] rd_pipe [RAM_RD_LAT];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read first on a same-address collision
    always_ff @(posedge clk) begin
        rd_pipe[0] <= mem[raddr];
        for (int i = 1; i < RAM_RD_LAT; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign rdata = rd_pipe[RAM_RD_LAT-1];

endmodule

/* hw/update_decode.sv */
module update_decode
    import pr_cfg_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                upd_valid,
    input  logic [V_AWIDTH-1:0] upd_addr,
    input  logic [V_VWIDTH-1:0] upd_value,
    input  logic                run_mode,
    input  logic                wb_done,
    output logic                stage_full,
    output logic                issue_valid,
    output logic [V_AWIDTH-1:0] issue_addr,
    output logic [V_VWIDTH-1:0] issue_value,
    output logic                fifo_empty
);

    logic [V_AWIDTH-1:0]       fifo_addr [FIFO_DEPTH];
    logic [V_VWIDTH-1:0]       fifo_value [FIFO_DEPTH];
    logic [FIFO_AWIDTH-1:0]    wr_ptr;
    logic [FIFO_AWIDTH-1:0]    rd_ptr;
    logic [FIFO_CWIDTH-1:0]    count;
    logic [FIFO_CWIDTH-1:0]    count_next;
    logic [INFLIGHT_WIDTH-1:0] outstanding;
    logic [INFLIGHT_WIDTH-1:0] outstanding_next;
    logic [V_AWIDTH-1:0]       win_addr [HAZARD_WINDOW];
    logic [HAZARD_WINDOW-1:0]  win_valid;   // bit 0 is the newest issue
    logic [HAZARD_WINDOW-1:0]  win_hit;
    logic                      push;
    logic                      pop;

    // prog-full leaves room for updates already on the way
    assign push = upd_valid && (count != FIFO_CWIDTH'(FIFO_DEPTH));

    always_comb begin
        for (int i = 0; i < HAZARD_WINDOW; i++) begin
            win_hit[i] = win_valid[i] && (win_addr[i] == fifo_addr[rd_ptr]);
        end
    end

    assign pop = run_mode && (count != '0) && !(|win_hit);

    assign count_next = count + FIFO_CWIDTH'(push) - FIFO_CWIDTH'(pop);
    assign outstanding_next = outstanding + INFLIGHT_WIDTH'(pop)
                              - INFLIGHT_WIDTH'(wb_done);

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_addr[wr_ptr] <= upd_addr;
            fifo_value[wr_ptr] <= upd_value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            outstanding <= '0;
            stage_full <= 1'b1;
            fifo_empty <= 1'b1;
            issue_valid <= 1'b0;
            win_valid <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            outstanding <= outstanding_next;
            stage_full <= !run_mode || (count_next >= FIFO_CWIDTH'(FIFO_PROG_FULL));
            fifo_empty <= (count_next == '0) && (outstanding_next == '0);  // also nothing pending
            issue_valid <= pop;
            win_valid <= {win_valid[HAZARD_WINDOW-2:0], pop};
        end
    end

    always_ff @(posedge clk) begin
        issue_addr <= fifo_addr[rd_ptr];
        issue_value <= fifo_value[rd_ptr];
        win_addr[0] <= fifo_addr[rd_ptr];
        for (int i = 1; i < HAZARD_WINDOW; i++) begin
            win_addr[i] <= win_addr[i-1];
        end
    end

    a_no_push_while_full: assert property (@(posedge clk) disable iff (rst)
        upd_valid |-> count != FIFO_CWIDTH'(FIFO_DEPTH));

    // every read must see the write-back of earlier updates to the same vertex
    for (genvar k = 1; k <= HAZARD_WINDOW; k++) begin : g_win_chk
        a_no_raw_hazard: assert property (@(posedge clk) disable iff (rst)
            issue_valid && $past(issue_valid, k) |-> issue_addr != $past(issue_addr, k));
    end

endmodule

/* hw/update_execute.sv */
module update_execute
    import pr_cfg_pkg::*;
    import pr_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  init_start,
    input  logic [V_VWIDTH-1:0]   init_pr,
    input  logic [ITER_WIDTH-1:0] iteration_id,
    input  logic                  issue_valid,
    input  logic [V_AWIDTH-1:0]   issue_addr,
    input  logic [V_VWIDTH-1:0]   issue_value,
    output logic                  run_mode,
    output logic                  init_done,
    output logic                  wb_valid,
    output logic [V_AWIDTH-1:0]   wb_addr,
    output logic [V_VWIDTH-1:0]   wb_pr,
    output logic [V_VWIDTH-1:0]   wb_delta
);

    localparam int L = RAM_RD_LAT - 1;

    core_state_e               state;
    logic [V_AWIDTH-1:0]       init_addr;
    logic [RAM_RD_LAT-1:0]     p_valid;
    logic [V_AWIDTH-1:0]       p_addr [RAM_RD_LAT];
    logic [V_VWIDTH-1:0]       p_value [RAM_RD_LAT];
    logic [ITER_WIDTH-1:0]     p_iter [RAM_RD_LAT];
    logic                      s_valid;
    logic [V_AWIDTH-1:0]       s_addr;
    logic [V_VWIDTH-1:0]       s_pr;
    logic [V_VWIDTH-1:0]       s_delta;
    logic [ITER_WIDTH-1:0]     s_iter;
    logic [V_VWIDTH-1:0]       pr_rdata;
    logic [DELTA_DWIDTH-1:0]   d0_rdata;
    logic [DELTA_DWIDTH-1:0]   d1_rdata;
    logic [DELTA_DWIDTH-1:0]   old_word;
    logic [V_VWIDTH-1:0]       old_delta;
    logic                      init_we;
    logic [V_AWIDTH-1:0]       ram_waddr;
    logic [V_VWIDTH-1:0]       pr_wdata;
    logic [DELTA_DWIDTH-1:0]   delta_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            init_addr <= '0;
            run_mode <= 1'b0;
            init_done <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (init_start) begin
                        state <= ST_INIT;
                        init_addr <= '0;
                    end
                end
                ST_INIT: begin
                    init_addr <= init_addr + 1'b1;
                    if (&init_addr) begin
                        state <= ST_RUN;
                        run_mode <= 1'b1;
                        init_done <= 1'b1;
                    end
                end
                default: state <= state;    // run is final
            endcase
        end
    end

    // issue info waits alongside the RAM read
    always_ff @(posedge clk) begin
        if (rst) begin
            p_valid <= '0;
            s_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            p_valid <= {p_valid[RAM_RD_LAT-2:0], issue_valid};
            s_valid <= p_valid[L];
            wb_valid <= s_valid;
        end
    end

    always_ff @(posedge clk) begin
        p_addr[0] <= issue_addr;
        p_value[0] <= issue_value;
        p_iter[0] <= iteration_id;
        for (int i = 1; i < RAM_RD_LAT; i++) begin
            p_addr[i] <= p_addr[i-1];
            p_value[i] <= p_value[i-1];
            p_iter[i] <= p_iter[i-1];
        end
    end

    always_comb begin
        old_word = p_iter[L][0] ? d1_rdata : d0_rdata;
        if (old_word[ITER_WIDTH-1:0] == p_iter[L]) begin
            old_delta = old_word[DELTA_DWIDTH-1:ITER_WIDTH];
        end else begin
            old_delta = '0;     // stale tag
        end
    end

    always_ff @(posedge clk) begin
        s_addr <= p_addr[L];
        s_pr <= pr_rdata + p_value[L];      // wraps
        s_delta <= old_delta + p_value[L];
        s_iter <= p_iter[L];
        wb_addr <= s_addr;
        wb_pr <= s_pr;
        wb_delta <= s_delta;
    end

    assign init_we = (state == ST_INIT);
    assign ram_waddr = init_we ? init_addr : s_addr;
    assign pr_wdata = init_we ? init_pr : s_pr;
    assign delta_wdata = init_we ? '0 : {s_delta, s_iter};

    vertex_ram #(.AWIDTH(V_AWIDTH), .DWIDTH(V_VWIDTH)) u_rank_ram (
        .clk   (clk),
        .we    (init_we || s_valid),
        .waddr (ram_waddr),
        .wdata (pr_wdata),
        .raddr (issue_addr),
        .rdata (pr_rdata)
    );

    vertex_ram #(.AWIDTH(V_AWIDTH), .DWIDTH(DELTA_DWIDTH)) u_delta0_ram (
        .clk   (clk),
        .we    (init_we || (s_valid && !s_iter[0])),
        .waddr (ram_waddr),
        .wdata (delta_wdata),
        .raddr (issue_addr),
        .rdata (d0_rdata)
    );

    vertex_ram #(.AWIDTH(V_AWIDTH), .DWIDTH(DELTA_DWIDTH)) u_delta1_ram (
        .clk   (clk),
        .we    (init_we || (s_valid && s_iter[0])),
        .waddr (ram_waddr),
        .wdata (delta_wdata),
        .raddr (issue_addr),
        .rdata (d1_rdata)
    );

    a_issue_only_in_run: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> state == ST_RUN);

endmodule

/* hw/active_result.sv */
module active_result
    import pr_cfg_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                issue_valid,
    input  logic                wb_valid,
    input  logic [V_AWIDTH-1:0] wb_addr,
    input  logic [V_VWIDTH-1:0] wb_pr,
    input  logic [V_VWIDTH-1:0] wb_delta,
    input  logic                fifo_empty,
    input  logic                iter_end_req,
    output logic [V_AWIDTH-1:0] active_v_id,
    output logic                active_v_updated,
    output logic [V_VWIDTH-1:0] active_delta,
    output logic                active_v_valid,
    output logic                iteration_end
);

    logic [INFLIGHT_WIDTH-1:0] inflight;
    logic                      drained;
    logic                      end_sent;

    assign drained = fifo_empty && (inflight == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight <= '0;
            active_v_valid <= 1'b0;
            iteration_end <= 1'b0;
            end_sent <= 1'b0;
        end else begin
            inflight <= inflight + INFLIGHT_WIDTH'(issue_valid)
                        - INFLIGHT_WIDTH'(wb_valid);
            active_v_valid <= wb_valid;
            iteration_end <= iter_end_req && drained && !end_sent;
            // one pulse per request
            if (!iter_end_req) begin
                end_sent <= 1'b0;
            end else if (drained) begin
                end_sent <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        active_v_id <= wb_addr;
        active_delta <= wb_delta;
        active_v_updated <= wb_delta > (wb_pr >> E2_SHIFT);
    end

    a_inflight_no_underflow: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> inflight != '0);

endmodule

/* hw/pr_vertex_core.sv */
module pr_vertex_core
    import pr_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  init_start,
    input  logic [V_VWIDTH-1:0]   init_pr,
    input  logic                  upd_valid,
    input  logic [V_AWIDTH-1:0]   upd_addr,
    input  logic [V_VWIDTH-1:0]   upd_value,
    input  logic [ITER_WIDTH-1:0] iteration_id,
    input  logic                  iter_end_req,
    output logic                  init_done,
    output logic                  stage_full,
    output logic [V_AWIDTH-1:0]   active_v_id,
    output logic                  active_v_updated,
    output logic [V_VWIDTH-1:0]   active_delta,
    output logic                  active_v_valid,
    output logic                  iteration_end
);

    logic                run_mode;
    logic                issue_valid;
    logic [V_AWIDTH-1:0] issue_addr;
    logic [V_VWIDTH-1:0] issue_value;
    logic                fifo_empty;
    logic                wb_valid;
    logic [V_AWIDTH-1:0] wb_addr;
    logic [V_VWIDTH-1:0] wb_pr;
    logic [V_VWIDTH-1:0] wb_delta;

    update_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .upd_valid   (upd_valid),
        .upd_addr    (upd_addr),
        .upd_value   (upd_value),
        .run_mode    (run_mode),
        .wb_done     (wb_valid),
        .stage_full  (stage_full),
        .issue_valid (issue_valid),
        .issue_addr  (issue_addr),
        .issue_value (issue_value),
        .fifo_empty  (fifo_empty)
    );

    update_execute u_execute (
        .clk          (clk),
        .rst          (rst),
        .init_start   (init_start),
        .init_pr      (init_pr),
        .iteration_id (iteration_id),
        .issue_valid  (issue_valid),
        .issue_addr   (issue_addr),
        .issue_value  (issue_value),
        .run_mode     (run_mode),
        .init_done    (init_done),
        .wb_valid     (wb_valid),
        .wb_addr      (wb_addr),
        .wb_pr        (wb_pr),
        .wb_delta     (wb_delta)
    );

    active_result u_result (
        .clk              (clk),
        .rst              (rst),
        .issue_valid      (issue_valid),
        .wb_valid         (wb_valid),
        .wb_addr          (wb_addr),
        .wb_pr            (wb_pr),
        .wb_delta         (wb_delta),
        .fifo_empty       (fifo_empty),
        .iter_end_req     (iter_end_req),
        .active_v_id      (active_v_id),
        .active_v_updated (active_v_updated),
        .active_delta     (active_delta),
        .active_v_valid   (active_v_valid),
        .iteration_end    (iteration_end)
    );

endmodule

/* tb/tb_clock.sv */
module tb_clock #(
    parameter int PERIOD = 100,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* tb/tb_pr_vertex_core.sv */
module tb_pr_vertex_core
    import pr_cfg_pkg::*;
;

    localparam logic [31:0] SEED = 32'ha0db95bd;
    localparam logic [V_VWIDTH-1:0] INIT_PR = 16'h0400;
    // fifo write and issue register come before the issue-to-result pipeline
    localparam int ACCEPT_TO_RESULT = ISSUE_TO_RESULT_LAT + 2;
    // about 70 init cycles, ~320 updates at up to 5 cycles each under conflicts, plus drains
    localparam int MAX_CYCLES = 3000;
    localparam int MAX_RESULTS = 512;
    // a near-full fifo of one address drains at one update per 5 cycles
    localparam int DRAIN_LIMIT = 100;

    logic                  clk;
    logic                  rst;
    logic                  init_start;
    logic [V_VWIDTH-1:0]   init_pr;
    logic                  upd_valid;
    logic [V_AWIDTH-1:0]   upd_addr;
    logic [V_VWIDTH-1:0]   upd_value;
    logic [ITER_WIDTH-1:0] iteration_id;
    logic                  iter_end_req;
    logic                  init_done;
    logic                  stage_full;
    logic [V_AWIDTH-1:0]   active_v_id;
    logic                  active_v_updated;
    logic [V_VWIDTH-1:0]   active_delta;
    logic                  active_v_valid;
    logic                  iteration_end;

    // reference model
    logic [V_VWIDTH-1:0]   m_rank [2**V_AWIDTH];
    logic [V_VWIDTH-1:0]   m_dval [2][2**V_AWIDTH];
    logic [ITER_WIDTH-1:0] m_dtag [2][2**V_AWIDTH];
    logic [V_AWIDTH-1:0]   exp_id [MAX_RESULTS];
    logic [V_VWIDTH-1:0]   exp_delta [MAX_RESULTS];
    logic                  exp_flag [MAX_RESULTS];
    logic [V_AWIDTH-1:0]   cur_exp_id;
    logic [V_VWIDTH-1:0]   cur_exp_delta;
    logic                  cur_exp_flag;

    int    acc_cnt;
    int    res_cnt;
    int    end_cnt;
    int    cycle_cnt;
    string test_name;
    logic  single_mode;
    logic  burst_mode;
    logic  saw_full;
    logic  chk_en;
    int    chk_exp;
    int    chk_act;

    tb_clock #(.PERIOD(100), .RST_CYCLES(4)) u_clock (
        .clk (clk),
        .rst (rst)
    );

    pr_vertex_core dut0 (
        .clk              (clk),
        .rst              (rst),
        .init_start       (init_start),
        .init_pr          (init_pr),
        .upd_valid        (upd_valid),
        .upd_addr         (upd_addr),
        .upd_value        (upd_value),
        .iteration_id     (iteration_id),
        .iter_end_req     (iter_end_req),
        .init_done        (init_done),
        .stage_full       (stage_full),
        .active_v_id      (active_v_id),
        .active_v_updated (active_v_updated),
        .active_delta     (active_delta),
        .active_v_valid   (active_v_valid),
        .iteration_end    (iteration_end)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    assign cur_exp_id = exp_id[res_cnt];
    assign cur_exp_delta = exp_delta[res_cnt];
    assign cur_exp_flag = exp_flag[res_cnt];

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (active_v_valid) begin
            res_cnt <= res_cnt + 1;
        end
        if (iteration_end) begin
            end_cnt <= end_cnt + 1;
        end
        if (burst_mode && stage_full) begin
            saw_full <= 1'b1;
        end
        if (cycle_cnt > MAX_CYCLES) begin
            stop_on_error("timeout: the run exceeded its cycle limit");
        end
    end

    a_full_until_init: assert property (@(posedge clk) disable iff (rst)
        !init_done |-> stage_full)
        else stop_on_error("stage_full dropped before init_done");

    a_init_time: assert property (@(posedge clk) disable iff (rst)
        $rose(init_done) |-> $past(init_start, 65))
        else stop_on_error("init_done did not rise 65 cycles after init_start");

    a_no_extra: assert property (@(posedge clk) disable iff (rst)
        active_v_valid |-> res_cnt < acc_cnt)
        else stop_on_error("result without a matching accepted update");

    a_res_id: assert property (@(posedge clk) disable iff (rst)
        active_v_valid |-> active_v_id == cur_exp_id)
        else stop_on_error($sformatf("CHECK FAILED %s id expected %0d actual %0d",
            test_name, $sampled(cur_exp_id), $sampled(active_v_id)));

    a_res_delta: assert property (@(posedge clk) disable iff (rst)
        active_v_valid |-> active_delta == cur_exp_delta)
        else stop_on_error($sformatf("CHECK FAILED %s delta expected %0d actual %0d",
            test_name, $sampled(cur_exp_delta), $sampled(active_delta)));

    a_res_flag: assert property (@(posedge clk) disable iff (rst)
        active_v_valid |-> active_v_updated == cur_exp_flag)
        else stop_on_error($sformatf("CHECK FAILED %s updated expected %0d actual %0d",
            test_name, $sampled(cur_exp_flag), $sampled(active_v_updated)));

    a_single_latency: assert property (@(posedge clk) disable iff (rst)
        active_v_valid && single_mode |-> $past(upd_valid, ACCEPT_TO_RESULT))
        else stop_on_error("single update result not at the expected latency");

    a_end_drained: assert property (@(posedge clk) disable iff (rst)
        iteration_end |-> res_cnt == acc_cnt && $past(iter_end_req))
        else stop_on_error("iteration_end pulsed with work still pending");

    a_checkpoint: assert property (@(posedge clk) disable iff (rst)
        chk_en |-> chk_act == chk_exp)
        else stop_on_error($sformatf("CHECK FAILED %s expected %0d actual %0d",
            test_name, $sampled(chk_exp), $sampled(chk_act)));

    task automatic checkpoint(input string name, input int exp_v, input int act_v);
        @(posedge clk);
        test_name = name;
        chk_en <= 1'b1;
        chk_exp <= exp_v;
        chk_act <= act_v;
        @(posedge clk);
        chk_en <= 1'b0;
    endtask

    // delta accumulates only on a matching tag, in the bank of the iteration parity
    task automatic model_update(input logic [V_AWIDTH-1:0] a, input logic [V_VWIDTH-1:0] v);
        logic                  bank;
        logic [V_VWIDTH-1:0]   d;
        logic [ITER_WIDTH-1:0] it;
        it = iteration_id;
        bank = it[0];
        if (m_dtag[bank][a] == it) begin
            d = m_dval[bank][a] + v;
        end else begin
            d = v;
        end
        m_dval[bank][a] = d;
        m_dtag[bank][a] = it;
        m_rank[a] = m_rank[a] + v;
        exp_id[acc_cnt] = a;
        exp_delta[acc_cnt] = d;
        exp_flag[acc_cnt] = d > (m_rank[a] >> E2_SHIFT);
        acc_cnt = acc_cnt + 1;
    endtask

    task automatic send_update(input logic [V_AWIDTH-1:0] a, input logic [V_VWIDTH-1:0] v);
        @(posedge clk);
        while (stage_full) begin
            upd_valid <= 1'b0;
            @(posedge clk);
        end
        upd_valid <= 1'b1;
        upd_addr <= a;
        upd_value <= v;
        model_update(a, v);
    endtask

    task automatic wait_drain();
        int waited;
        @(posedge clk);
        upd_valid <= 1'b0;
        waited = 0;
        while (res_cnt != acc_cnt && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        repeat (2) @(posedge clk);
    endtask

    initial begin
        int i;
        int base;
        init_start = 1'b0;
        init_pr = INIT_PR;
        upd_valid = 1'b0;
        upd_addr = '0;
        upd_value = '0;
        iteration_id = '0;
        iter_end_req = 1'b0;
        acc_cnt = 0;
        res_cnt = 0;
        end_cnt = 0;
        cycle_cnt = 0;
        single_mode = 1'b0;
        burst_mode = 1'b0;
        saw_full = 1'b0;
        chk_en = 1'b0;
        chk_exp = 0;
        chk_act = 0;
        test_name = "init";
        void'($urandom(SEED));
        for (i = 0; i < 2**V_AWIDTH; i++) begin
            m_rank[i] = INIT_PR;
            m_dval[0][i] = '0;
            m_dval[1][i] = '0;
            m_dtag[0][i] = '0;
            m_dtag[1][i] = '0;
        end

        @(posedge clk);
        while (rst) @(posedge clk);
        init_start <= 1'b1;
        @(posedge clk);
        init_start <= 1'b0;
        while (!init_done) @(posedge clk);

        test_name = "single";
        single_mode = 1'b1;
        send_update(6'd40, 16'd100);
        wait_drain();
        single_mode = 1'b0;

        test_name = "random";
        for (i = 0; i < 200; i++) begin
            send_update(V_AWIDTH'($urandom_range(7, 0)), V_VWIDTH'($urandom_range(127, 0)));
            if ($urandom_range(3, 0) == 0) begin
                @(posedge clk);
                upd_valid <= 1'b0;
            end
        end
        wait_drain();

        // parity 1 then 0 again, tags left from iteration 0 are stale
        test_name = "iteration";
        for (int it = 1; it <= 2; it++) begin
            @(posedge clk);
            iteration_id <= ITER_WIDTH'(it);
            @(posedge clk);
            for (i = 0; i < 32; i++) begin
                send_update(V_AWIDTH'($urandom_range(7, 0)), V_VWIDTH'($urandom_range(63, 1)));
            end
            wait_drain();
        end

        test_name = "burst";
        burst_mode = 1'b1;
        for (i = 0; i < 40; i++) begin
            send_update(6'd5, 16'd3);
        end
        wait_drain();
        burst_mode = 1'b0;
        checkpoint("burst stage_full", 1, int'(saw_full));
        checkpoint("burst count", acc_cnt, res_cnt);

        base = end_cnt;
        test_name = "iter_end idle";
        @(posedge clk);
        iter_end_req <= 1'b1;
        repeat (10) @(posedge clk);
        iter_end_req <= 1'b0;
        repeat (2) @(posedge clk);
        checkpoint("iter_end idle", 1, end_cnt - base);

        base = end_cnt;
        test_name = "iter_end busy";
        for (i = 0; i < 8; i++) begin
            send_update(6'd20, V_VWIDTH'($urandom_range(255, 0)));
            if (i == 1) begin
                iter_end_req <= 1'b1;
            end
        end
        wait_drain();
        repeat (8) @(posedge clk);
        iter_end_req <= 1'b0;
        repeat (2) @(posedge clk);
        checkpoint("iter_end busy", 1, end_cnt - base);

        $display("All tests passed");
        $finish;
    end

endmodule

/* sources.f */
hw/pr_cfg_pkg.sv
hw/pr_types_pkg.sv
hw/vertex_ram.sv
hw/update_decode.sv
hw/update_execute.sv
hw/active_result.sv
hw/pr_vertex_core.sv
tb/tb_clock.sv
tb/tb_pr_vertex_core.sv

/* Makefile */
TOP = tb_pr_vertex_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o vsim
	./obj_dir/vsim

clean:
	rm -rf obj_dir
